//--- build.f
+incdir+tb
hdl/mac_mem_pkg.sv
hdl/phase_gen.sv
hdl/reset_seq.sv
hdl/image_loader.sv
hdl/mem_arbiter.sv
hdl/word_ram.sv
hdl/mac_mem_top.sv
tb/tb_top.sv

//--- hdl/image_loader.sv
//==========================================================
// host download loader: byte pairing, region addressing,
// memory write requests and disk image classification
//==========================================================
`default_nettype none

module image_loader (
  input  wire                        RESET,
  input  wire                        clk_sys,
  input  wire                        dl_active_i,
  input  wire [mac_mem_pkg::INDEX_W-1:0] dl_index_i,
  input  wire                        dl_valid_i,
  input  wire [mac_mem_pkg::BYTE_W-1:0]  dl_byte_i,
  input  wire [1:0]                  eject_i,
  input  wire                        ld_ready_i,
  output logic                       dl_ready_o,
  output logic                       ld_valid_o,
  output mac_mem_pkg::addr_t         ld_addr_o,
  output mac_mem_pkg::word_t         ld_data_o,
  output logic [1:0]                 disk_inserted_o,
  output logic [1:0]                 disk_double_o
);

  import mac_mem_pkg::*;

  logic               run_q;
  logic               act_q;
  logic [INDEX_W-1:0] idx_q;
  logic               have_hi;
  logic [BYTE_W-1:0]  hi_byte;
  addr_t              word_cnt;
  addr_t              cnt_cur;
  addr_t              region_base;
  logic               start_dl;
  logic               end_dl;
  logic               hi_full;
  logic               byte_fire;
  logic [1:0]         disk_sel;

  assign start_dl  = dl_active_i & ~act_q;
  assign end_dl    = ~dl_active_i & act_q;
  // a fresh download discards any half word and restarts the count
  assign hi_full   = have_hi & ~start_dl;
  assign cnt_cur   = start_dl ? '0 : word_cnt;
  // stall the host while a finished word waits for its grant
  assign dl_ready_o = run_q & ~ld_valid_o;
  assign byte_fire  = dl_valid_i & dl_ready_o;
  assign disk_sel   = {idx_q == IDX_DISK_EXT, idx_q == IDX_DISK_INT};

  always_comb begin
    case (dl_index_i)
      IDX_ROM:      region_base = ROM_BASE;
      IDX_DISK_INT: region_base = DISK_INT_BASE;
      IDX_DISK_EXT: region_base = DISK_EXT_BASE;
      default:      region_base = ROM_BASE;
    endcase
  end

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      run_q      <= 1'b0;
      act_q      <= 1'b0;
      idx_q      <= '0;
      have_hi    <= 1'b0;
      word_cnt   <= '0;
      ld_valid_o <= 1'b0;
    end else begin
      run_q <= 1'b1;
      act_q <= dl_active_i;
      if (dl_active_i) begin
        idx_q <= dl_index_i;
      end
      if (byte_fire && !hi_full) begin
        have_hi  <= 1'b1;
        word_cnt <= cnt_cur;
      end else if (byte_fire) begin
        have_hi    <= 1'b0;
        ld_valid_o <= 1'b1;
        word_cnt   <= cnt_cur + 1'b1;
      end else if (start_dl) begin
        have_hi  <= 1'b0;
        word_cnt <= '0;
      end
      if (ld_valid_o && ld_ready_i) begin
        ld_valid_o <= 1'b0;
      end
    end
  end

  // payload, only meaningful while ld_valid_o is high
  always_ff @(posedge clk_sys) begin
    if (byte_fire && !hi_full) begin
      hi_byte <= dl_byte_i;
    end else if (byte_fire) begin
      ld_data_o <= {hi_byte, dl_byte_i};
      ld_addr_o <= region_base + (cnt_cur & addr_t'(REGION_WORDS - 1));
    end
  end

  //==========================================================
  // disk status, eject wins over a finishing download
  //==========================================================
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      disk_inserted_o <= '0;
      disk_double_o   <= '0;
    end else begin
      for (int d = 0; d < 2; d++) begin
        if (eject_i[d]) begin
          disk_inserted_o[d] <= 1'b0;
          disk_double_o[d]   <= 1'b0;
        end else if (end_dl && disk_sel[d]) begin
          disk_inserted_o[d] <= (word_cnt == addr_t'(DISK_DS_WORDS)) ||
                                (word_cnt == addr_t'(DISK_SS_WORDS));
          disk_double_o[d]   <= (word_cnt == addr_t'(DISK_DS_WORDS));
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/mac_mem_pkg.sv
//==========================================================
// shared widths, word types, download indices, region map,
// disk image sizes and clock-enable phase constants
//==========================================================
`default_nettype none

package mac_mem_pkg;

  // word and byte geometry
  localparam int WORD_W  = 16;
  localparam int BYTE_W  = 8;
  localparam int LANES   = WORD_W / BYTE_W;
  localparam int ADDR_W  = 9;
  localparam int INDEX_W = 8;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [ADDR_W-1:0] addr_t;
  // lane 1 is the upper byte
  typedef logic [LANES-1:0]  lanes_t;

  //==========================================================
  // download indices and memory map
  //==========================================================
  localparam logic [INDEX_W-1:0] IDX_ROM      = 8'd0;
  localparam logic [INDEX_W-1:0] IDX_DISK_INT = 8'd1;
  localparam logic [INDEX_W-1:0] IDX_DISK_EXT = 8'd2;

  localparam addr_t ROM_BASE      = addr_t'(0);
  localparam addr_t DISK_INT_BASE = addr_t'(128);
  localparam addr_t DISK_EXT_BASE = addr_t'(256);

  // each region wraps at this many words
  localparam int REGION_WORDS = 128;

  // image sizes in words, scaled down from 800k and 400k floppies
  localparam int DISK_DS_WORDS = 64;
  localparam int DISK_SS_WORDS = 32;

  //==========================================================
  // clock-enable phases and reset timing
  //==========================================================
  localparam int DIV_W = 3;

  localparam logic [DIV_W-1:0] CEP_PHASE = 3'd0;
  localparam logic [DIV_W-1:0] CEN_PHASE = 3'd4;
  localparam logic [DIV_W-1:0] CEL_PHASE = 3'd7;

  localparam int SYNC_STAGES = 5;
  localparam int RST_CNT_W   = 4;

endpackage

`default_nettype wire

//--- hdl/mac_mem_top.sv
//==========================================================
// memory and housekeeping core: phases, reset,
// image loader, arbiter and shared word memory
//==========================================================
`default_nettype none

module mac_mem_top (
  input  wire                            RESET,
  input  wire                            clk_sys,
  input  wire                            pll_locked_i,
  input  wire                            user_reset_i,
  input  wire                            dl_active_i,
  input  wire [mac_mem_pkg::INDEX_W-1:0] dl_index_i,
  input  wire                            dl_valid_i,
  input  wire [mac_mem_pkg::BYTE_W-1:0]  dl_byte_i,
  output logic                           dl_ready_o,
  input  wire                            cpu_valid_i,
  output logic                           cpu_ready_o,
  input  wire                            cpu_we_i,
  input  wire [mac_mem_pkg::ADDR_W-1:0]  cpu_addr_i,
  input  wire [mac_mem_pkg::LANES-1:0]   cpu_lanes_i,
  input  wire [mac_mem_pkg::WORD_W-1:0]  cpu_wdata_i,
  output logic                           cpu_rd_valid_o,
  output mac_mem_pkg::word_t             cpu_rdata_o,
  input  wire [1:0]                      eject_i,
  output logic [1:0]                     disk_inserted_o,
  output logic [1:0]                     disk_double_o,
  output logic                           sys_reset_n_o,
  output logic                           cep_o,
  output logic                           cen_o,
  output logic                           cel_o,
  output logic                           cepix_o
);

  import mac_mem_pkg::*;

  // loader write request
  logic   ld_valid;
  logic   ld_ready;
  addr_t  ld_addr;
  word_t  ld_data;

  // shared memory port
  logic   mem_en;
  logic   mem_we;
  addr_t  mem_addr;
  lanes_t mem_lanes;
  word_t  mem_wdata;
  word_t  mem_rdata;

  phase_gen u_phase (
    .RESET(RESET), .clk_sys(clk_sys),
    .cep_o(cep_o), .cen_o(cen_o), .cel_o(cel_o), .cepix_o(cepix_o)
  );

  reset_seq u_reset (
    .RESET(RESET), .clk_sys(clk_sys), .pll_locked_i(pll_locked_i),
    .user_reset_i(user_reset_i), .cen_i(cen_o), .sys_reset_n_o(sys_reset_n_o)
  );

  image_loader u_loader (
    .RESET(RESET), .clk_sys(clk_sys), .dl_active_i(dl_active_i),
    .dl_index_i(dl_index_i), .dl_valid_i(dl_valid_i), .dl_byte_i(dl_byte_i),
    .eject_i(eject_i), .ld_ready_i(ld_ready), .dl_ready_o(dl_ready_o),
    .ld_valid_o(ld_valid), .ld_addr_o(ld_addr), .ld_data_o(ld_data),
    .disk_inserted_o(disk_inserted_o), .disk_double_o(disk_double_o)
  );

  mem_arbiter u_arb (
    .RESET(RESET), .clk_sys(clk_sys), .ld_valid_i(ld_valid),
    .ld_addr_i(ld_addr), .ld_data_i(ld_data), .cpu_valid_i(cpu_valid_i),
    .cpu_we_i(cpu_we_i), .cpu_addr_i(cpu_addr_i), .cpu_lanes_i(cpu_lanes_i),
    .cpu_wdata_i(cpu_wdata_i), .mem_rdata_i(mem_rdata), .ld_ready_o(ld_ready),
    .cpu_ready_o(cpu_ready_o), .cpu_rd_valid_o(cpu_rd_valid_o),
    .cpu_rdata_o(cpu_rdata_o), .mem_en_o(mem_en), .mem_we_o(mem_we),
    .mem_addr_o(mem_addr), .mem_lanes_o(mem_lanes), .mem_wdata_o(mem_wdata)
  );

  word_ram u_ram (
    .clk_sys(clk_sys), .mem_en_i(mem_en), .mem_we_i(mem_we),
    .mem_addr_i(mem_addr), .mem_lanes_i(mem_lanes), .mem_wdata_i(mem_wdata),
    .mem_rdata_o(mem_rdata)
  );

endmodule

`default_nettype wire

//--- hdl/mem_arbiter.sv
//==========================================================
// round-robin arbiter between loader and cpu port,
// memory port mux and cpu read return
//==========================================================
`default_nettype none

module mem_arbiter (
  input  wire                 RESET,
  input  wire                 clk_sys,
  input  wire                 ld_valid_i,
  input  mac_mem_pkg::addr_t  ld_addr_i,
  input  mac_mem_pkg::word_t  ld_data_i,
  input  wire                 cpu_valid_i,
  input  wire                 cpu_we_i,
  input  mac_mem_pkg::addr_t  cpu_addr_i,
  input  mac_mem_pkg::lanes_t cpu_lanes_i,
  input  mac_mem_pkg::word_t  cpu_wdata_i,
  input  mac_mem_pkg::word_t  mem_rdata_i,
  output logic                ld_ready_o,
  output logic                cpu_ready_o,
  output logic                cpu_rd_valid_o,
  output mac_mem_pkg::word_t  cpu_rdata_o,
  output logic                mem_en_o,
  output logic                mem_we_o,
  output mac_mem_pkg::addr_t  mem_addr_o,
  output mac_mem_pkg::lanes_t mem_lanes_o,
  output mac_mem_pkg::word_t  mem_wdata_o
);

  import mac_mem_pkg::*;

  logic live_q;
  logic last_cpu;
  logic rd_tag;
  logic grant_ld;
  logic grant_cpu;

  // the loser of the last contested cycle goes first
  assign grant_ld  = live_q & ld_valid_i & (~cpu_valid_i | last_cpu);
  assign grant_cpu = live_q & cpu_valid_i & ~grant_ld;

  assign ld_ready_o  = grant_ld;
  assign cpu_ready_o = grant_cpu;

  //==========================================================
  // memory port mux, loader words always write both lanes
  //==========================================================
  assign mem_en_o    = grant_ld | grant_cpu;
  assign mem_we_o    = grant_ld | cpu_we_i;
  assign mem_addr_o  = grant_ld ? ld_addr_i : cpu_addr_i;
  assign mem_lanes_o = grant_ld ? lanes_t'('1) : cpu_lanes_i;
  assign mem_wdata_o = grant_ld ? ld_data_i : cpu_wdata_i;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      live_q   <= 1'b0;
      last_cpu <= 1'b0;
      rd_tag   <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (live_q && ld_valid_i && cpu_valid_i) begin
        last_cpu <= grant_cpu;
      end
      // read data of an accepted cpu read returns next cycle
      rd_tag <= grant_cpu & ~cpu_we_i;
    end
  end

  assign cpu_rd_valid_o = rd_tag;
  assign cpu_rdata_o    = mem_rdata_i;

endmodule

`default_nettype wire

//--- hdl/phase_gen.sv
//==========================================================
// free-running phase divider with registered
// cep, cen, cel and pixel clock enables
//==========================================================
`default_nettype none

module phase_gen (
  input  wire  RESET,
  input  wire  clk_sys,
  output logic cep_o,
  output logic cen_o,
  output logic cel_o,
  output logic cepix_o
);

  import mac_mem_pkg::*;

  logic [DIV_W-1:0] div;

  // strobe is high the cycle after the divider sat on its phase
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      div     <= '0;
      cep_o   <= 1'b0;
      cen_o   <= 1'b0;
      cel_o   <= 1'b0;
      cepix_o <= 1'b0;
    end else begin
      div     <= div + 1'b1;
      cep_o   <= (div == CEP_PHASE);
      cen_o   <= (div == CEN_PHASE);
      cel_o   <= (div == CEL_PHASE);
      // pixel enable runs at twice the cpu phase rate
      cepix_o <= (div[1:0] == 2'b00);
    end
  end

endmodule

`default_nettype wire

//--- hdl/reset_seq.sv
//==========================================================
// reset synchronizer and stretched system reset
//==========================================================
`default_nettype none

module reset_seq (
  input  wire  RESET,
  input  wire  clk_sys,
  input  wire  pll_locked_i,
  input  wire  user_reset_i,
  input  wire  cen_i,
  output logic sys_reset_n_o
);

  import mac_mem_pkg::*;

  logic [SYNC_STAGES-1:0] sync_q;
  logic                   sync_reset;
  logic                   hold;
  logic [RST_CNT_W-1:0]   rst_cnt;

  // asserts with RESET, drains one stage per clock
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      sync_q <= '1;
    end else begin
      sync_q <= {sync_q[SYNC_STAGES-2:0], 1'b0};
    end
  end

  assign sync_reset = sync_q[SYNC_STAGES-1];

  // any of these restarts the stretch
  assign hold = sync_reset | ~pll_locked_i | user_reset_i;

  // stretch counter, reloaded while hold is high and drained by cen
  always_ff @(posedge clk_sys) begin
    if (hold) begin
      rst_cnt <= '1;
    end else if (cen_i && (rst_cnt != '0)) begin
      rst_cnt <= rst_cnt - 1'b1;
    end
  end

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      sys_reset_n_o <= 1'b0;
    end else begin
      sys_reset_n_o <= ~hold && (rst_cnt == '0);
    end
  end

endmodule

`default_nettype wire

//--- hdl/word_ram.sv
//==========================================================
// on-chip word memory with byte-lane writes
// and registered one-cycle read
//==========================================================
`default_nettype none

module word_ram (
  input  wire                        clk_sys,
  input  wire                        mem_en_i,
  input  wire                        mem_we_i,
  input  wire [mac_mem_pkg::ADDR_W-1:0] mem_addr_i,
  input  wire [mac_mem_pkg::LANES-1:0]  mem_lanes_i,
  input  wire [mac_mem_pkg::WORD_W-1:0] mem_wdata_i,
  output mac_mem_pkg::word_t         mem_rdata_o
);

  import mac_mem_pkg::*;

  localparam int DEPTH = 2 ** ADDR_W;

  word_t mem [DEPTH];

  //==========================================================
  // write enabled lanes, or read into the output register
  //==========================================================
  always_ff @(posedge clk_sys) begin
    if (mem_en_i) begin
      if (mem_we_i) begin
        for (int l = 0; l < LANES; l++) begin
          if (mem_lanes_i[l]) begin
            mem[mem_addr_i][l*BYTE_W +: BYTE_W] <= mem_wdata_i[l*BYTE_W +: BYTE_W];
          end
        end
      end else begin
        // read data appears the cycle after the request
        mem_rdata_o <= mem[mem_addr_i];
      end
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build the mac_mem_top testbench with Verilator and run it
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f build.f --top-module tb_top -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished with status 0"
exit 0

//--- tb/tb_model.svh
//============================================================
// reference model: shadow memory, expected cpu read data,
// byte-lane merge, region map, disk status, strobe timing
//============================================================
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// shadow of the shared memory and which words hold known data
word_t shadow [2**ADDR_W];
bit    known  [2**ADDR_W];
// read data owed to the cpu, oldest first
word_t exp_rd_q [$];

// only the enabled lanes take the new byte, lane 1 is the upper byte
function automatic word_t merge_lanes(word_t old, word_t wdata, lanes_t lanes);
  word_t w;
  w = old;
  for (int l = 0; l < LANES; l++) begin
    if (lanes[l]) begin
      w[l*BYTE_W +: BYTE_W] = wdata[l*BYTE_W +: BYTE_W];
    end
  end
  return w;
endfunction

// word n of a download lands in its region and wraps there
function automatic addr_t word_addr(logic [INDEX_W-1:0] idx, int n);
  addr_t base;
  base = ROM_BASE;
  if (idx == IDX_DISK_INT) begin
    base = DISK_INT_BASE;
  end else if (idx == IDX_DISK_EXT) begin
    base = DISK_EXT_BASE;
  end
  return base + addr_t'(n % REGION_WORDS);
endfunction

// status left by a disk download of this many words
task automatic disk_expect(input int words, output logic ins, output logic dbl);
  ins = (words == DISK_DS_WORDS) || (words == DISK_SS_WORDS);
  dbl = (words == DISK_DS_WORDS);
endtask

// strobes k cycles after a cep pulse, as {cep, cen, cel, cepix}
task automatic strobe_expect(input int k, output logic [3:0] s);
  int ph;
  ph = k % 8;
  s = {ph == 0, ph == 4, ph == 7, (k % 4) == 0};
endtask

`endif

//--- tb/tb_top.sv
//============================================================
// testbench for mac_mem_top: strobes, reset release, image
// downloads, disk status and shared-memory traffic
//============================================================
`default_nettype none

module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  import mac_mem_pkg::*;

  `include "tb_model.svh"

  logic               RESET, clk_sys, pll_locked, user_reset;
  logic               dl_active, dl_valid, dl_ready;
  logic [INDEX_W-1:0] dl_index;
  logic [BYTE_W-1:0]  dl_byte;
  logic               cpu_valid, cpu_ready, cpu_we, cpu_rd_valid;
  addr_t              cpu_addr;
  lanes_t             cpu_lanes;
  word_t              cpu_wdata, cpu_rdata;
  logic [1:0]         eject, disk_ins, disk_dbl;
  logic               sys_reset_n, cep, cen, cel, cepix;

  // control values for the next falling edge
  logic               pll_nx, ureset_nx, act_nx;
  logic [INDEX_W-1:0] idx_nx;
  logic [1:0]         eject_nx;
  integer             seed;
  logic [BYTE_W-1:0]  dl_bytes [$];
  logic [BYTE_W-1:0]  hi_byte;
  int                 dl_sent, cpu_ops, cpu_span, cpu_next, waited;
  addr_t              cpu_base;
  bit                 cpu_rand, dl_fire, cpu_fire, rd_due;

  mac_mem_top dut0 (
    .RESET(RESET), .clk_sys(clk_sys), .pll_locked_i(pll_locked),
    .user_reset_i(user_reset), .dl_active_i(dl_active), .dl_index_i(dl_index),
    .dl_valid_i(dl_valid), .dl_byte_i(dl_byte), .dl_ready_o(dl_ready),
    .cpu_valid_i(cpu_valid), .cpu_ready_o(cpu_ready), .cpu_we_i(cpu_we),
    .cpu_addr_i(cpu_addr), .cpu_lanes_i(cpu_lanes), .cpu_wdata_i(cpu_wdata),
    .cpu_rd_valid_o(cpu_rd_valid), .cpu_rdata_o(cpu_rdata), .eject_i(eject),
    .disk_inserted_o(disk_ins), .disk_double_o(disk_dbl), .sys_reset_n_o(sys_reset_n),
    .cep_o(cep), .cen_o(cen), .cel_o(cel), .cepix_o(cepix)
  );

  initial begin
    clk_sys = 1'b0;
    forever #50 clk_sys = ~clk_sys;
  end

  task automatic abort_run();
    $display("Errors found");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
    abort_run();
  endtask

  // one more cycle of a bounded wait
  task automatic tick_or_fail(input int limit, input string what);
    step();
    waited++;
    if (waited > limit) begin
      $display("timeout: %s", what);
      abort_run();
    end
  endtask

  // random traffic in the spare region, or sequential reads
  task automatic new_cpu_req();
    addr_t a;
    if (cpu_rand) begin
      a = cpu_base + addr_t'($unsigned($random(seed)) % cpu_span);
      cpu_we    = !known[a] || (($random(seed) & 1) != 0);
      cpu_lanes = known[a] ? lanes_t'($random(seed)) : 2'b11;
    end else begin
      a = cpu_base + addr_t'(cpu_next);
      cpu_next++;
      cpu_we    = 1'b0;
      cpu_lanes = 2'b11;
    end
    cpu_addr  = a;
    cpu_wdata = word_t'($random(seed));
    cpu_ops--;
  endtask

  //============================================================
  // one clock: drive on the falling edge, sample before the rise
  //============================================================
  task automatic step();
    word_t exp;
    addr_t wa;
    @(negedge clk_sys);
    {pll_locked, user_reset, dl_active} = {pll_nx, ureset_nx, act_nx};
    dl_index = idx_nx;
    eject    = eject_nx;
    // requests are held until taken
    if (!dl_valid || dl_fire) begin
      dl_valid = dl_active && (dl_sent < dl_bytes.size()) && (($random(seed) & 3) != 0);
      dl_byte  = dl_valid ? dl_bytes[dl_sent] : '0;
    end
    if (!cpu_valid || cpu_fire) begin
      cpu_valid = (cpu_ops > 0) && (($random(seed) & 3) != 0);
      if (cpu_valid) begin
        new_cpu_req();
      end
    end
    #40;
    if (rd_due) begin
      exp = exp_rd_q.pop_front();
      assert (cpu_rd_valid === 1'b1) else value_error("cpu_rd_valid_o", 32'(cpu_rd_valid), 1);
      assert (cpu_rdata === exp) else value_error("cpu_rdata_o", 32'(cpu_rdata), 32'(exp));
    end else begin
      assert (cpu_rd_valid === 1'b0) else value_error("cpu_rd_valid_o", 32'(cpu_rd_valid), 0);
    end
    dl_fire  = dl_valid && dl_ready;
    cpu_fire = cpu_valid && cpu_ready;
    rd_due   = cpu_fire && !cpu_we;
    if (cpu_fire && cpu_we) begin
      shadow[cpu_addr] = merge_lanes(shadow[cpu_addr], cpu_wdata, cpu_lanes);
      known[cpu_addr]  = 1'b1;
    end else if (cpu_fire) begin
      exp_rd_q.push_back(shadow[cpu_addr]);
    end
    if (dl_fire) begin
      // upper byte first
      if (dl_sent % 2 == 0) begin
        hi_byte = dl_byte;
      end else begin
        wa = word_addr(dl_index, dl_sent / 2);
        shadow[wa] = {hi_byte, dl_byte};
        known[wa]  = 1'b1;
      end
      dl_sent++;
    end
  endtask

  task automatic run_cpu(input addr_t base, input int span, input int ops, input bit rnd);
    {cpu_base, cpu_span, cpu_ops, cpu_rand, cpu_next} = {base, span, ops, rnd, 32'd0};
    waited = 0;
    if (!rnd) begin
      while (cpu_ops > 0 || cpu_valid || rd_due) begin
        tick_or_fail(20 * ops + 20, "cpu reads were not served");
      end
    end
  endtask

  // send an image of random bytes, then check the disk status it leaves
  task automatic download(input logic [INDEX_W-1:0] idx, input int words);
    logic ins, dbl, d;
    dl_bytes.delete();
    repeat (2 * words) dl_bytes.push_back(8'($random(seed)));
    {dl_sent, idx_nx, act_nx} = {32'd0, idx, 1'b1};
    waited = 0;
    while (dl_sent < dl_bytes.size() || dl_active === 1'b1 || dl_ready !== 1'b1) begin
      act_nx = (dl_sent < dl_bytes.size());
      tick_or_fail(30 * words + 50, "download stalled or never drained");
    end
    step();
    if (idx != IDX_ROM) begin
      d = (idx == IDX_DISK_EXT);
      disk_expect(words, ins, dbl);
      assert ({disk_ins[d], disk_dbl[d]} === {ins, dbl})
        else value_error("disk_inserted_o/disk_double_o", 32'({disk_ins[d], disk_dbl[d]}),
                         32'({ins, dbl}));
    end
  endtask

  initial begin
    logic [3:0] s;
    seed = 32'h97701027;
    RESET = 1'b1;
    {pll_locked, user_reset, dl_active, dl_valid, cpu_valid, cpu_we} = '0;
    {dl_index, dl_byte, cpu_addr, cpu_lanes, cpu_wdata, eject} = '0;
    {pll_nx, ureset_nx, act_nx, idx_nx, eject_nx} = '0;
    {dl_sent, cpu_ops, rd_due, dl_fire, cpu_fire} = '0;
    repeat (4) @(negedge clk_sys);
    RESET = 1'b0;

    // strobe phases, first pll unlocked and then a user reset hold the system
    // in reset for longer than the stretch takes
    waited = 0;
    while (cep !== 1'b1) begin
      tick_or_fail(16, "cep never pulsed after reset");
    end
    for (int k = 0; k < 400; k++) begin
      strobe_expect(k, s);
      assert ({cep, cen, cel, cepix} === s)
        else value_error("cep_o/cen_o/cel_o/cepix_o", 32'({cep, cen, cel, cepix}), 32'(s));
      assert (sys_reset_n === 1'b0) else value_error("sys_reset_n_o", 32'(sys_reset_n), 0);
      if (k == 200) begin
        {pll_nx, ureset_nx} = 2'b11;
      end
      step();
    end

    // release, then a user reset pulse and a second release
    ureset_nx = 1'b0;
    waited = 0;
    while (sys_reset_n !== 1'b1) begin
      tick_or_fail(600, "system reset was never released");
    end
    ureset_nx = 1'b1;
    waited = 0;
    while (sys_reset_n !== 1'b0) begin
      tick_or_fail(4, "user reset did not assert the system reset");
    end
    ureset_nx = 1'b0;
    waited = 0;
    while (sys_reset_n !== 1'b1) begin
      tick_or_fail(600, "system reset was not released after the user reset");
    end

    // rom image and disk images, read back through the cpu port
    download(IDX_ROM, 40);
    run_cpu(ROM_BASE, 40, 40, 1'b0);
    download(IDX_DISK_INT, DISK_DS_WORDS);
    download(IDX_DISK_EXT, DISK_SS_WORDS);
    run_cpu(DISK_INT_BASE, DISK_DS_WORDS, DISK_DS_WORDS, 1'b0);
    run_cpu(DISK_EXT_BASE, DISK_SS_WORDS, DISK_SS_WORDS, 1'b0);
    // an odd size replaces the single-sided status of the external disk
    download(IDX_DISK_EXT, 45);
    run_cpu(DISK_EXT_BASE, 45, 45, 1'b0);
    // the internal disk is still double-sided until its eject
    eject_nx = 2'b01;
    step();
    eject_nx = 2'b00;
    step();
    assert ({disk_ins, disk_dbl} === 4'b0000)
      else value_error("disk_inserted_o/disk_double_o", 32'({disk_ins, disk_dbl}), 0);

    // random cpu traffic in the spare quarter during a rom download
    run_cpu(addr_t'(384), 128, 300, 1'b1);
    download(IDX_ROM, 100);
    waited = 0;
    while (cpu_ops > 0 || cpu_valid || rd_due) begin
      tick_or_fail(3000, "cpu traffic was not served");
    end
    run_cpu(ROM_BASE, 100, 100, 1'b0);

    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire
